// File: design/i2c_ctrl.sv
`timescale 1ns/1ps

module i2c_ctrl (
	input  logic                clk_i,
	input  logic                rst_i,
	input  i2c_pkg::xfer_cmd_s  cmd_i,
	input  i2c_pkg::scl_tick_s  tick_i,
	input  logic                sda_i,
	input  logic                tx_bit_i,
	input  logic                bit_last_i,
	input  logic                byte_last_i,
	input  logic [31:0]         rx_byte_i,
	output logic                run_o,
	output logic                sda_oe_o,
	output logic                load_o,
	output logic                shift_o,
	output logic                capture_o,
	output logic                next_byte_o,
	output logic [7:0]          addr_byte_o,
	output logic                addr_phase_o,
	output i2c_pkg::xfer_stat_s stat_o
);

	i2c_pkg::i2c_state_e state_q;
	logic                read_q;
	logic                nack_q;
	logic                done_q;
	logic                rdata_we_q;
	logic                in_byte;

	assign in_byte = (state_q == i2c_pkg::S_ADDR) || (state_q == i2c_pkg::S_WDATA) ||
		(state_q == i2c_pkg::S_RDATA);

	assign addr_byte_o  = {cmd_i.addr7, cmd_i.read};
	assign addr_phase_o = (state_q == i2c_pkg::S_ADDR);
	assign load_o       = (state_q == i2c_pkg::S_IDLE) && cmd_i.go;
	assign shift_o      = tick_i.fall && in_byte;
	assign capture_o    = tick_i.mid_high && (state_q == i2c_pkg::S_RDATA);
	// nack_q only ever rises on a written byte, which ends the transfer.
	assign next_byte_o  = tick_i.fall && (state_q == i2c_pkg::S_ACK1) && !nack_q && !byte_last_i;

	always_comb begin
		stat_o.done_pulse = done_q;
		stat_o.nack       = nack_q;
		stat_o.rdata      = rx_byte_i;
		stat_o.rdata_we   = rdata_we_q;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q    <= i2c_pkg::S_IDLE;
			read_q     <= 1'b0;
			nack_q     <= 1'b0;
			done_q     <= 1'b0;
			rdata_we_q <= 1'b0;
			run_o      <= 1'b0;
			sda_oe_o   <= 1'b0;
		end else begin
			done_q     <= 1'b0;
			rdata_we_q <= 1'b0;
			case (state_q)
				i2c_pkg::S_IDLE: begin
					if (cmd_i.go) begin
						read_q  <= cmd_i.read;
						nack_q  <= 1'b0;
						run_o   <= 1'b1;
						state_q <= i2c_pkg::S_START;
					end
				end
				i2c_pkg::S_START: begin
					if (tick_i.mid_high) begin
						sda_oe_o <= 1'b1;
					end
					if (tick_i.fall) begin
						state_q <= i2c_pkg::S_ADDR;
					end
				end
				i2c_pkg::S_ADDR, i2c_pkg::S_WDATA: begin
					if (tick_i.mid_low) begin
						sda_oe_o <= ~tx_bit_i;
					end
					if (tick_i.fall && bit_last_i) begin
						state_q <= (state_q == i2c_pkg::S_ADDR) ? i2c_pkg::S_ACK0 : i2c_pkg::S_ACK1;
					end
				end
				i2c_pkg::S_ACK0: begin
					if (tick_i.mid_low) begin
						sda_oe_o <= 1'b0;
					end
					if (tick_i.mid_high) begin
						nack_q <= sda_i;
					end
					if (tick_i.fall) begin
						if (nack_q) begin
							state_q <= i2c_pkg::S_STOP;
						end else begin
							state_q <= read_q ? i2c_pkg::S_RDATA : i2c_pkg::S_WDATA;
						end
					end
				end
				i2c_pkg::S_RDATA: begin
					if (tick_i.mid_low) begin
						sda_oe_o <= 1'b0;
					end
					if (tick_i.fall && bit_last_i) begin
						rdata_we_q <= 1'b1;
						state_q    <= i2c_pkg::S_ACK1;
					end
				end
				i2c_pkg::S_ACK1: begin
					// on reads the master acks every byte but the last.
					if (tick_i.mid_low) begin
						sda_oe_o <= read_q && !byte_last_i;
					end
					if (tick_i.mid_high && !read_q) begin
						nack_q <= sda_i;
					end
					if (tick_i.fall) begin
						if (nack_q || byte_last_i) begin
							state_q <= i2c_pkg::S_STOP;
						end else begin
							state_q <= read_q ? i2c_pkg::S_RDATA : i2c_pkg::S_WDATA;
						end
					end
				end
				i2c_pkg::S_STOP: begin
					if (tick_i.mid_low) begin
						sda_oe_o <= 1'b1;
					end
					if (tick_i.mid_high) begin
						sda_oe_o <= 1'b0;
						run_o    <= 1'b0;
						done_q   <= 1'b1;
						state_q  <= i2c_pkg::S_IDLE;
					end
				end
				default: state_q <= i2c_pkg::S_IDLE;
			endcase
		end
	end

endmodule

// File: design/i2c_master.sv
`timescale 1ns/1ps

module i2c_master (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic               req_i,
	input  i2c_pkg::host_req_s host_req_i,
	output logic               ack_o,
	output logic [31:0]        rdata_o,
	input  logic               sda_i,
	output logic               sda_oe_o,
	output logic               scl_o
);

	i2c_pkg::xfer_cmd_s  cmd;
	i2c_pkg::xfer_stat_s stat;
	i2c_pkg::scl_tick_s  tick;
	logic                run;
	logic                load;
	logic                shift;
	logic                capture;
	logic                next_byte;
	logic [7:0]          addr_byte;
	logic                addr_phase;
	logic                tx_bit;
	logic                bit_last;
	logic                byte_last;
	logic [31:0]         rx_word;

	i2c_regs regs0 (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.req_i      (req_i),
		.host_req_i (host_req_i),
		.ack_o      (ack_o),
		.rdata_o    (rdata_o),
		.cmd_o      (cmd),
		.stat_i     (stat)
	);

	i2c_scl_gen scl_gen0 (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.run_i  (run),
		.scl_o  (scl_o),
		.tick_o (tick)
	);

	i2c_ctrl ctrl0 (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.cmd_i        (cmd),
		.tick_i       (tick),
		.sda_i        (sda_i),
		.tx_bit_i     (tx_bit),
		.bit_last_i   (bit_last),
		.byte_last_i  (byte_last),
		.rx_byte_i    (rx_word),
		.run_o        (run),
		.sda_oe_o     (sda_oe_o),
		.load_o       (load),
		.shift_o      (shift),
		.capture_o    (capture),
		.next_byte_o  (next_byte),
		.addr_byte_o  (addr_byte),
		.addr_phase_o (addr_phase),
		.stat_o       (stat)
	);

	i2c_shifter shifter0 (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.load_i       (load),
		.tdata_i      (cmd.tdata),
		.addr_byte_i  (addr_byte),
		.nbytes_i     (cmd.nbytes),
		.addr_phase_i (addr_phase),
		.shift_i      (shift),
		.capture_i    (capture),
		.next_byte_i  (next_byte),
		.sda_i        (sda_i),
		.tx_bit_o     (tx_bit),
		.bit_last_o   (bit_last),
		.byte_last_o  (byte_last),
		.rx_word_o    (rx_word)
	);

endmodule

// File: design/i2c_pkg.sv
package i2c_pkg;

	// host register map.
	localparam logic [4:0] REG_NBY = 5'd0;
	localparam logic [4:0] REG_ADR = 5'd4;
	localparam logic [4:0] REG_RDR = 5'd8;
	localparam logic [4:0] REG_TDR = 5'd12;
	localparam logic [4:0] REG_CFG = 5'd16;

	// bit positions inside the CFG register.
	localparam int CFG_START_WR = 0;
	localparam int CFG_START_RD = 1;
	localparam int CFG_BUSY     = 2;
	localparam int CFG_DONE     = 3;
	localparam int CFG_NACK     = 4;

	// clk_i cycles per SCL half period.
	localparam logic [7:0] SCL_HALF = 8'd125;

	typedef enum logic [2:0] {
		S_IDLE,
		S_START,
		S_ADDR,
		S_ACK0,
		S_WDATA,
		S_RDATA,
		S_ACK1,
		S_STOP
	} i2c_state_e;

	// command decoded from the start bits of CFG.
	typedef enum logic [1:0] {
		CMD_NONE,
		CMD_WRITE,
		CMD_READ
	} i2c_cmd_e;

	typedef struct packed {
		logic        write;
		logic [3:0]  be;
		logic [4:0]  addr;
		logic [31:0] wdata;
	} host_req_s;

	typedef struct packed {
		logic        go;
		logic        read;
		logic [2:0]  nbytes;
		logic [6:0]  addr7;
		logic [31:0] tdata;
	} xfer_cmd_s;

	typedef struct packed {
		logic        done_pulse;
		logic        nack;
		logic [31:0] rdata;
		logic        rdata_we;
	} xfer_stat_s;

	typedef struct packed {
		logic rise;
		logic fall;
		logic mid_high;
		logic mid_low;
	} scl_tick_s;

endpackage

// File: design/i2c_regs.sv
`timescale 1ns/1ps

module i2c_regs (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                req_i,
	input  i2c_pkg::host_req_s  host_req_i,
	output logic                ack_o,
	output logic [31:0]         rdata_o,
	output i2c_pkg::xfer_cmd_s  cmd_o,
	input  i2c_pkg::xfer_stat_s stat_i
);

	logic              req_q;
	logic [31:0]       nby_q;
	logic [31:0]       adr_q;
	logic [31:0]       tdr_q;
	logic [31:0]       rdr_q;
	logic [4:0]        cfg_q;
	logic [31:0]       rd_mux;
	logic [31:0]       wmask;
	logic [31:0]       wdata;
	logic              access;
	logic              wr_en;
	i2c_pkg::i2c_cmd_e cmd;

	// the access happens on the first cycle req_i has been seen high.
	assign access = req_q && !ack_o;
	assign wr_en  = access && host_req_i.write;
	assign wdata  = host_req_i.wdata;
	assign wmask  = {{8{host_req_i.be[3]}}, {8{host_req_i.be[2]}},
		{8{host_req_i.be[1]}}, {8{host_req_i.be[0]}}};

	always_comb begin
		case (host_req_i.addr)
			i2c_pkg::REG_NBY: rd_mux = nby_q;
			i2c_pkg::REG_ADR: rd_mux = adr_q;
			i2c_pkg::REG_RDR: rd_mux = rdr_q;
			i2c_pkg::REG_TDR: rd_mux = tdr_q;
			i2c_pkg::REG_CFG: rd_mux = {27'd0, cfg_q};
			default:          rd_mux = 32'd0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			req_q <= 1'b0;
			ack_o <= 1'b0;
		end else begin
			req_q <= req_i;
			if (access) begin
				ack_o <= 1'b1;
			end else if (!req_q) begin
				ack_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (access) begin
			rdata_o <= rd_mux;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			nby_q <= 32'd0;
			adr_q <= 32'd0;
			tdr_q <= 32'd0;
			rdr_q <= 32'd0;
			cfg_q <= 5'd0;
		end else begin
			// start bits live for a single cycle, the controller is idle whenever BUSY is clear.
			if (cmd_o.go) begin
				cfg_q[i2c_pkg::CFG_START_WR] <= 1'b0;
				cfg_q[i2c_pkg::CFG_START_RD] <= 1'b0;
			end
			if (wr_en) begin
				case (host_req_i.addr)
					i2c_pkg::REG_NBY: nby_q <= (nby_q & ~wmask) | (wdata & wmask);
					i2c_pkg::REG_ADR: adr_q <= (adr_q & ~wmask) | (wdata & wmask);
					i2c_pkg::REG_RDR: rdr_q <= (rdr_q & ~wmask) | (wdata & wmask);
					i2c_pkg::REG_TDR: tdr_q <= (tdr_q & ~wmask) | (wdata & wmask);
					i2c_pkg::REG_CFG: begin
						cfg_q[i2c_pkg::CFG_DONE] <= 1'b0;
						cfg_q[i2c_pkg::CFG_NACK] <= 1'b0;
						if (host_req_i.be[0]) begin
							cfg_q[i2c_pkg::CFG_START_WR] <= wdata[i2c_pkg::CFG_START_WR];
							cfg_q[i2c_pkg::CFG_START_RD] <= wdata[i2c_pkg::CFG_START_RD];
							if (wdata[i2c_pkg::CFG_START_WR] || wdata[i2c_pkg::CFG_START_RD]) begin
								cfg_q[i2c_pkg::CFG_BUSY] <= 1'b1;
							end
						end
					end
					default: ;
				endcase
			end
			if (stat_i.rdata_we) begin
				rdr_q <= stat_i.rdata;
			end
			if (stat_i.done_pulse) begin
				cfg_q[i2c_pkg::CFG_BUSY] <= 1'b0;
				cfg_q[i2c_pkg::CFG_DONE] <= 1'b1;
				cfg_q[i2c_pkg::CFG_NACK] <= stat_i.nack;
			end
		end
	end

	always_comb begin
		case ({cfg_q[i2c_pkg::CFG_START_RD], cfg_q[i2c_pkg::CFG_START_WR]})
			2'b00:   cmd = i2c_pkg::CMD_NONE;
			2'b01:   cmd = i2c_pkg::CMD_WRITE;
			default: cmd = i2c_pkg::CMD_READ;
		endcase
		cmd_o.go    = (cmd != i2c_pkg::CMD_NONE);
		cmd_o.read  = (cmd == i2c_pkg::CMD_READ);
		cmd_o.addr7 = adr_q[6:0];
		cmd_o.tdata = tdr_q;
		// a count outside 1 to 4 is clamped to the nearest legal value.
		if (nby_q == 32'd0) begin
			cmd_o.nbytes = 3'd1;
		end else if (nby_q > 32'd4) begin
			cmd_o.nbytes = 3'd4;
		end else begin
			cmd_o.nbytes = nby_q[2:0];
		end
	end

endmodule

// File: design/i2c_scl_gen.sv
`timescale 1ns/1ps

module i2c_scl_gen (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic               run_i,
	output logic               scl_o,
	output i2c_pkg::scl_tick_s tick_o
);

	logic [7:0] cnt_q;
	logic       wrap;
	logic       mid;

	assign wrap = (cnt_q == i2c_pkg::SCL_HALF - 8'd1);
	assign mid  = (cnt_q == (i2c_pkg::SCL_HALF >> 1));

	// the bus idles with SCL high, so a stopped divider parks there.
	always_ff @(posedge clk_i) begin
		if (rst_i || !run_i) begin
			cnt_q <= 8'd0;
			scl_o <= 1'b1;
		end else if (wrap) begin
			cnt_q <= 8'd0;
			scl_o <= ~scl_o;
		end else begin
			cnt_q <= cnt_q + 8'd1;
		end
	end

	// ticks lead the SCL edge they announce by one cycle.
	always_comb begin
		tick_o.rise     = run_i && wrap && !scl_o;
		tick_o.fall     = run_i && wrap && scl_o;
		tick_o.mid_high = run_i && mid && scl_o;
		tick_o.mid_low  = run_i && mid && !scl_o;
	end

endmodule

// File: design/i2c_shifter.sv
`timescale 1ns/1ps

module i2c_shifter (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        load_i,
	input  logic [31:0] tdata_i,
	input  logic [7:0]  addr_byte_i,
	input  logic [2:0]  nbytes_i,
	input  logic        addr_phase_i,
	input  logic        shift_i,
	input  logic        capture_i,
	input  logic        next_byte_i,
	input  logic        sda_i,
	output logic        tx_bit_o,
	output logic        bit_last_o,
	output logic        byte_last_o,
	output logic [31:0] rx_word_o
);

	logic [2:0]  bit_q;
	logic [1:0]  byte_q;
	logic [2:0]  last_idx;
	logic [4:0]  pos;
	logic [31:0] tdata_q;
	logic [7:0]  addr_q;

	// the highest byte goes first, so the index counts down from nbytes - 1.
	assign last_idx    = nbytes_i - 3'd1;
	assign pos         = {byte_q, bit_q};
	assign tx_bit_o    = addr_phase_i ? addr_q[bit_q] : tdata_q[pos];
	assign bit_last_o  = (bit_q == 3'd0);
	assign byte_last_o = (byte_q == 2'd0);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			bit_q  <= 3'd7;
			byte_q <= 2'd0;
		end else if (load_i) begin
			bit_q  <= 3'd7;
			byte_q <= last_idx[1:0];
		end else begin
			// the bit counter wraps from 0 back to 7 on its own.
			if (shift_i) begin
				bit_q <= bit_q - 3'd1;
			end
			if (next_byte_i) begin
				byte_q <= byte_q - 2'd1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (load_i) begin
			tdata_q   <= tdata_i;
			addr_q    <= addr_byte_i;
			rx_word_o <= 32'd0;
		end else if (capture_i) begin
			rx_word_o[pos] <= sda_i;
		end
	end

endmodule

// File: i2c_master.f
design/i2c_pkg.sv
design/i2c_regs.sv
design/i2c_scl_gen.sv
design/i2c_ctrl.sv
design/i2c_shifter.sv
design/i2c_master.sv
sim/i2c_slave_model.sv
sim/i2c_checker.sv
sim/i2c_master_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the testbench with Verilator, then searches the log for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f i2c_master.f --top-module i2c_master_tb \
	-o sim_i2c > build.log 2>&1 \
	&& ./obj_dir/sim_i2c > sim.log 2>&1 \
	|| { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

cat sim.log
grep -qx "Done: no errors" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: sim/i2c_checker.sv
`timescale 1ns/1ps

module i2c_checker (
	input logic clk_i,
	input logic rst_i,
	input logic scl_i,
	input logic sda_i,
	input logic idle_i
);

	// bus events are {1'b0, byte, ack} for bytes, START and STOP use the top bit.
	localparam logic [9:0] EV_START = 10'h200;
	localparam logic [9:0] EV_STOP  = 10'h201;

	logic [9:0] expq[$];
	logic [8:0] shreg;
	logic       idle_err_seen;
	int         bit_cnt;
	int         reg_errors;
	int         bus_errors;

	initial begin
		shreg         = 9'd0;
		idle_err_seen = 1'b0;
		bit_cnt       = 0;
		reg_errors    = 0;
		bus_errors    = 0;
	end

	task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			reg_errors++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic push_start();
		expq.push_back(EV_START);
	endtask

	task automatic push_stop();
		expq.push_back(EV_STOP);
	endtask

	task automatic push_byte(input logic [7:0] b, input logic nack);
		expq.push_back({1'b0, b, nack});
	endtask

	function automatic int pending();
		return expq.size();
	endfunction

	task automatic check_event(input logic [9:0] ev);
		logic [9:0] exp;
		if (expq.size() == 0) begin
			bus_errors++;
			$display("bus event %h seen while none was expected", ev);
		end else begin
			exp = expq.pop_front();
			if (exp !== ev) begin
				bus_errors++;
				$display("FAILED bus_event expected %h actual %h", exp, ev);
			end
		end
	endtask

	always @(negedge sda_i) begin
		if (rst_i === 1'b0 && scl_i === 1'b1) begin
			bit_cnt = 0;
			check_event(EV_START);
		end
	end

	// the STOP bit brings one SCL rise before SDA goes high.
	always @(posedge sda_i) begin
		if (rst_i === 1'b0 && scl_i === 1'b1) begin
			if (bit_cnt != 1) begin
				bus_errors++;
				$display("STOP came in the middle of a byte");
			end
			bit_cnt = 0;
			check_event(EV_STOP);
		end
	end

	always @(posedge scl_i) begin
		if (rst_i === 1'b0) begin
			shreg   = {shreg[7:0], sda_i};
			bit_cnt = bit_cnt + 1;
			if (bit_cnt == 9) begin
				bit_cnt = 0;
				check_event({1'b0, shreg});
			end
		end
	end

	always @(posedge clk_i) begin
		if (rst_i === 1'b0 && idle_i && (scl_i !== 1'b1 || sda_i !== 1'b1)) begin
			if (!idle_err_seen) begin
				bus_errors++;
				$display("bus left the idle state while no transfer was running");
				idle_err_seen = 1'b1;
			end
		end
	end

endmodule

// File: sim/i2c_master_tb.sv
`timescale 1ns/1ps

module i2c_master_tb;

	localparam logic [6:0] TB_SLAVE_ADDR = 7'h2a;
	localparam int NUM_XFERS = 10;
	localparam int CYCLE_LIMIT = NUM_XFERS * (2 + 9 * 5) * 2 * int'(i2c_pkg::SCL_HALF) + 2000;

	logic               clk_i;
	logic               rst_i;
	logic               req_i;
	i2c_pkg::host_req_s host_req_i;
	logic               ack_o;
	logic [31:0]        rdata_o;
	logic               sda_oe_m;
	logic               sda_oe_s;
	logic               scl;
	logic               sda;
	logic [31:0]        slv_mem;
	logic [2:0]         slv_nbytes;
	logic [2:0]         slv_nack;
	logic               idle;
	logic [31:0]        rdr_exp;
	logic [31:0]        shadow[4];
	logic [31:0]        val;
	int                 cycles;

	// wired-AND bus with pull-up.
	assign sda = !(sda_oe_m || sda_oe_s);

	i2c_master dut0 (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.req_i      (req_i),
		.host_req_i (host_req_i),
		.ack_o      (ack_o),
		.rdata_o    (rdata_o),
		.sda_i      (sda),
		.sda_oe_o   (sda_oe_m),
		.scl_o      (scl)
	);

	i2c_slave_model #(.ADDR(TB_SLAVE_ADDR)) slave0 (
		.scl_i       (scl),
		.sda_i       (sda),
		.mem_i       (slv_mem),
		.nbytes_i    (slv_nbytes),
		.nack_byte_i (slv_nack),
		.sda_oe_o    (sda_oe_s)
	);

	i2c_checker chk0 (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.scl_i  (scl),
		.sda_i  (sda),
		.idle_i (idle)
	);

	always #20 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
			$display("Done: errors found");
			$finish;
		end
	end

	function automatic logic [31:0] merge_be(input logic [31:0] old, input logic [31:0] wr,
		input logic [3:0] be);
		logic [31:0] res;
		res = old;
		for (int k = 0; k < 4; k++) begin
			if (be[k]) begin
				res[k * 8 +: 8] = wr[k * 8 +: 8];
			end
		end
		return res;
	endfunction

	// byte k of the slave memory lands in byte k of RDR. Bytes above the count stay zero.
	function automatic logic [31:0] expect_rdr(input logic [31:0] mem, input int n);
		logic [31:0] res;
		res = 32'd0;
		for (int k = n - 1; k >= 0; k--) begin
			res[k * 8 +: 8] = mem[k * 8 +: 8];
		end
		return res;
	endfunction

	task automatic host_access(input logic write, input logic [4:0] addr, input logic [3:0] be,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int n;
		@(posedge clk_i);
		#2;
		host_req_i.write = write;
		host_req_i.be    = be;
		host_req_i.addr  = addr;
		host_req_i.wdata = wdata;
		req_i = 1'b1;
		n = 0;
		do begin
			@(posedge clk_i);
			#2;
			n++;
		end while (!ack_o);
		rdata = rdata_o;
		chk0.compare_word("ack_rise_cycles", 32'd2, n);
		req_i = 1'b0;
		n = 0;
		do begin
			@(posedge clk_i);
			#2;
			n++;
		end while (ack_o);
		chk0.compare_word("ack_fall_cycles", 32'd2, n);
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [3:0] be, input logic [31:0] data);
		logic [31:0] unused;
		host_access(1'b1, addr, be, data, unused);
	endtask

	task automatic read_reg(input logic [4:0] addr, output logic [31:0] data);
		host_access(1'b0, addr, 4'h0, 32'd0, data);
	endtask

	task automatic run_xfer(input logic rd, input int n, input logic [6:0] addr7,
		input logic [2:0] nack_at);
		logic [31:0] tdata;
		logic [31:0] rv;
		logic [7:0]  b;
		logic        addr_ok;
		logic        stop_early;
		logic        nack_bit;
		logic        nack_exp;
		tdata      = $urandom;
		slv_mem    = $urandom;
		slv_nbytes = 3'(n);
		slv_nack   = nack_at;
		write_reg(i2c_pkg::REG_NBY, 4'hf, 32'(n));
		write_reg(i2c_pkg::REG_ADR, 4'hf, {25'd0, addr7});
		write_reg(i2c_pkg::REG_TDR, 4'hf, tdata);
		addr_ok    = (addr7 == TB_SLAVE_ADDR);
		stop_early = !addr_ok;
		nack_exp   = !addr_ok;
		chk0.push_start();
		chk0.push_byte({addr7, rd}, !addr_ok);
		for (int i = 0; i < n && !stop_early; i++) begin
			if (rd) begin
				b = slv_mem[(n - 1 - i) * 8 +: 8];
				nack_bit = (i == n - 1);
			end else begin
				b = tdata[(n - 1 - i) * 8 +: 8];
				nack_bit = (i == int'(nack_at));
				stop_early = nack_bit;
				nack_exp = nack_exp || nack_bit;
			end
			chk0.push_byte(b, nack_bit);
		end
		chk0.push_stop();
		idle = 1'b0;
		write_reg(i2c_pkg::REG_CFG, 4'h1, rd ? 32'd2 : 32'd1);
		do begin
			read_reg(i2c_pkg::REG_CFG, rv);
		end while (rv[i2c_pkg::CFG_BUSY]);
		idle = 1'b1;
		chk0.compare_word("cfg", {27'd0, nack_exp, 1'b1, 3'b000}, rv);
		if (rd && addr_ok) begin
			rdr_exp = expect_rdr(slv_mem, n);
		end
		read_reg(i2c_pkg::REG_RDR, rv);
		chk0.compare_word("rdr", rdr_exp, rv);
		chk0.compare_word("bus_events_left", 32'd0, chk0.pending());
	endtask

	initial begin
		logic [31:0] w;
		logic [3:0]  be;
		void'($urandom(32'h37db_a9f9));
		clk_i      = 1'b0;
		rst_i      = 1'b1;
		req_i      = 1'b0;
		host_req_i = '0;
		slv_mem    = 32'd0;
		slv_nbytes = 3'd1;
		slv_nack   = 3'd7;
		idle       = 1'b0;
		rdr_exp    = 32'd0;
		cycles     = 0;
		repeat (3) @(posedge clk_i);
		#2;
		rst_i = 1'b0;
		idle  = 1'b1;

		read_reg(i2c_pkg::REG_CFG, val);
		chk0.compare_word("cfg", 32'd0, val);
		for (int i = 0; i < 4; i++) begin
			w = $urandom;
			write_reg(5'(i * 4), 4'hf, w);
			shadow[i] = w;
			w = $urandom;
			be = 4'($urandom);
			write_reg(5'(i * 4), be, w);
			shadow[i] = merge_be(shadow[i], w, be);
		end
		for (int i = 0; i < 4; i++) begin
			read_reg(5'(i * 4), val);
			chk0.compare_word($sformatf("reg_%0d", i * 4), shadow[i], val);
		end
		rdr_exp = shadow[2];
		read_reg(i2c_pkg::REG_CFG, val);
		chk0.compare_word("cfg", 32'd0, val);

		for (int n = 1; n <= 4; n++) begin
			run_xfer(1'b0, n, TB_SLAVE_ADDR, 3'd7);
		end
		for (int n = 1; n <= 4; n++) begin
			run_xfer(1'b1, n, TB_SLAVE_ADDR, 3'd7);
		end
		// a read to an absent slave must leave RDR as the last read left it.
		run_xfer(1'b1, 1 + int'($urandom % 4), 7'h15, 3'd7);
		run_xfer(1'b0, 2 + int'($urandom % 3), TB_SLAVE_ADDR, 3'd1);

		repeat (10) @(posedge clk_i);
		$display("register errors: %0d, bus errors: %0d", chk0.reg_errors, chk0.bus_errors);
		if (chk0.reg_errors + chk0.bus_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: sim/i2c_slave_model.sv
`timescale 1ns/1ps

module i2c_slave_model #(
	parameter logic [6:0] ADDR = 7'h2a
) (
	input  logic        scl_i,
	input  logic        sda_i,
	input  logic [31:0] mem_i,
	input  logic [2:0]  nbytes_i,
	input  logic [2:0]  nack_byte_i,
	output logic        sda_oe_o
);

	logic       active;
	logic       is_addr;
	logic       reading;
	logic       master_ack;
	logic [7:0] shreg;
	logic [7:0] cur;
	int         bit_cnt;
	int         byte_idx;

	initial begin
		sda_oe_o   = 1'b0;
		active     = 1'b0;
		is_addr    = 1'b0;
		reading    = 1'b0;
		master_ack = 1'b0;
		bit_cnt    = 0;
		byte_idx   = 0;
	end

	// START and STOP are SDA edges while SCL is high.
	always @(negedge sda_i) begin
		if (scl_i === 1'b1) begin
			active   = 1'b1;
			is_addr  = 1'b1;
			reading  = 1'b0;
			// the SCL fall that closes START carries no bit.
			bit_cnt  = -1;
			byte_idx = 0;
			sda_oe_o <= 1'b0;
		end
	end

	always @(posedge sda_i) begin
		if (scl_i === 1'b1) begin
			active = 1'b0;
			sda_oe_o <= 1'b0;
		end
	end

	always @(posedge scl_i) begin
		if (active) begin
			if (bit_cnt < 8) begin
				shreg = {shreg[6:0], sda_i};
			end else begin
				master_ack = !sda_i;
			end
		end
	end

	// the slave changes SDA only right after SCL falls.
	always @(negedge scl_i) begin
		if (active) begin
			if (bit_cnt == 7) begin
				bit_cnt = 8;
				if (is_addr) begin
					if (shreg[7:1] == ADDR) begin
						reading = shreg[0];
						sda_oe_o <= 1'b1;
					end else begin
						active = 1'b0;
						sda_oe_o <= 1'b0;
					end
				end else if (reading) begin
					sda_oe_o <= 1'b0;
				end else begin
					sda_oe_o <= (byte_idx != int'(nack_byte_i));
				end
			end else if (bit_cnt == 8) begin
				bit_cnt = 0;
				if (reading && (is_addr || master_ack)) begin
					cur = mem_i[(int'(nbytes_i) - 1 - byte_idx) * 8 +: 8];
					byte_idx = byte_idx + 1;
					sda_oe_o <= !cur[7];
				end else begin
					if (!reading && !is_addr) begin
						byte_idx = byte_idx + 1;
					end
					sda_oe_o <= 1'b0;
				end
				is_addr = 1'b0;
			end else begin
				bit_cnt = bit_cnt + 1;
				if (reading && !is_addr) begin
					sda_oe_o <= !cur[7 - bit_cnt];
				end
			end
		end
	end

endmodule
